// ==== kbd_tests.txt ====
// Columns, all hex: release code input_gap ack_delay (gap = idle cycles before key_req,
// ack_delay = cycles from seeing out_req to raising out_ack). First value: event count
0f
// Single press
0 1c 00 02
// Release of the same key, then press and release pairs
1 1c 03 00
0 32 05 01
1 32 02 03
0 f0 00 00
1 f0 07 04
// Burst of 8 with no input gap and slow sink, deeper than the FIFO
0 15 00 30
1 15 00 30
0 16 00 30
0 2a 00 30
1 16 00 30
1 2a 00 30
0 5a 00 30
1 5a 00 30
// Tail event after the burst drains
0 76 02 00

// ==== all.f ====
+incdir+.
kbd_pkg.sv
kbd_key_port.sv
kbd_device.sv
kbd_poller.sv
kbd_io_top.sv
tb_kbd_io.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_kbd_io
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_kbd_io.sv ====
/*
 * Testbench for the keyboard input subsystem
 * Replays key events from kbd_tests.txt through the input handshake and
 * checks that each one leaves the output handshake once, in order
 */

`timescale 1ns/1ps

module tb_kbd_io;

  localparam int MAX_EVENTS = 32;
  localparam int MEM_WORDS  = 1 + 4 * MAX_EVENTS;
  // Cycle limits for the handshake waits
  localparam int ACK_LIMIT  = 2000;
  localparam int DROP_LIMIT = 20;
  localparam int OUT_LIMIT  = 4000;
  // Quiet windows after reset and after the last event
  localparam int IDLE_CYCLES  = 20;
  localparam int DRAIN_CYCLES = 64;

  logic                clk;
  logic                rst_n;
  logic                key_req;
  kbd_pkg::key_event_t key_in;
  logic                key_ack;
  logic                out_req;
  kbd_pkg::key_event_t out_event;
  logic                out_ack;

  // Word 0 holds the event count and four words follow per event
  logic [7:0] test_mem [0:MEM_WORDS-1];
  int         n_events;
  int         out_count;
  // Rising edges of out_req seen by the monitor
  int         out_pulses;

  // Handshake monitor state sampled on falling edges
  logic                key_req_seen;
  logic                prev_key_req;
  logic                prev_key_ack;
  logic                prev_out_req;
  logic                prev_out_ack;
  kbd_pkg::key_event_t prev_out_event;

  // Poller state shown in timeout messages
  kbd_pkg::poll_state_t poll_state;
  assign poll_state = dut.u_poller.state;

  kbd_io_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .key_req   (key_req),
    .key_in    (key_in),
    .key_ack   (key_ack),
    .out_req   (out_req),
    .out_event (out_event),
    .out_ack   (out_ack)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at first failure");
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t ns waiting for %s, poller in state %s",
             $time, what, poll_state.name());
    fail_run();
  endtask

  // Compare one output event against the file
  task automatic check_event(input kbd_pkg::key_event_t got, input kbd_pkg::key_event_t exp);
    if (got !== exp) begin
      $display("ERROR %0t: event %0d came out as release=%b code=%h, %s release=%b code=%h",
               $time, out_count, got[8], got[7:0], "expected", exp[8], exp[7:0]);
      fail_run();
    end
  endtask

  // Compare one handshake flag
  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
      fail_run();
    end
  endtask

  // Release is bit 0 of the first column and code is the second
  function automatic kbd_pkg::key_event_t event_at(input int idx);
    return kbd_pkg::key_event_t'({test_mem[1 + 4 * idx][0], test_mem[2 + 4 * idx]});
  endfunction

  function automatic int gap_at(input int idx);
    return int'(test_mem[3 + 4 * idx]);
  endfunction

  function automatic int delay_at(input int idx);
    return int'(test_mem[4 + 4 * idx]);
  endfunction

  // Input agent on the source side of the four-phase key port
  task automatic drive_inputs();
    int wait_cnt;
    for (int i = 0; i < n_events; i++) begin
      repeat (gap_at(i)) @(posedge clk);
      @(posedge clk);
      key_in  <= event_at(i);
      key_req <= 1'b1;
      wait_cnt = 0;
      @(negedge clk);
      while (!key_ack) begin
        if (wait_cnt == ACK_LIMIT) report_timeout("key_ack to rise");
        wait_cnt++;
        @(negedge clk);
      end
      @(posedge clk);
      key_req <= 1'b0;
      wait_cnt = 0;
      @(negedge clk);
      while (key_ack) begin
        if (wait_cnt == DROP_LIMIT) report_timeout("key_ack to fall");
        wait_cnt++;
        @(negedge clk);
      end
    end
  endtask

  // Output agent on the sink side with events expected in file order
  task automatic serve_outputs();
    int                  wait_cnt;
    kbd_pkg::key_event_t exp_ev;
    for (int i = 0; i < n_events; i++) begin
      exp_ev   = event_at(i);
      wait_cnt = 0;
      @(negedge clk);
      while (!out_req) begin
        if (wait_cnt == OUT_LIMIT) report_timeout("out_req to rise");
        wait_cnt++;
        @(negedge clk);
      end
      check_event(out_event, exp_ev);
      // Hold off the ack to build back-pressure
      repeat (delay_at(i)) @(posedge clk);
      @(posedge clk);
      out_ack <= 1'b1;
      wait_cnt = 0;
      @(negedge clk);
      while (out_req) begin
        if (wait_cnt == DROP_LIMIT) report_timeout("out_req to fall");
        wait_cnt++;
        @(negedge clk);
      end
      @(posedge clk);
      out_ack <= 1'b0;
      out_count++;
    end
  endtask

  // Handshake rules at the top ports
  always @(negedge clk) begin
    if (!rst_n) begin
      key_req_seen = 1'b0;
    end else begin
      check_flag("out_req ahead of any key_req", out_req & ~key_req_seen, 1'b0);
      if (key_ack && !prev_key_ack) check_flag("key_req under rising key_ack", prev_key_req, 1'b1);
      if (!out_req && prev_out_req) check_flag("out_ack under falling out_req", prev_out_ack, 1'b1);
      if (out_req && prev_out_req) begin
        check_flag("out_event stable under out_req", out_event === prev_out_event, 1'b1);
      end
      if (out_req && !prev_out_req) out_pulses++;
      if (key_req) key_req_seen = 1'b1;
    end
    prev_key_req   = key_req;
    prev_key_ack   = key_ack;
    prev_out_req   = out_req;
    prev_out_ack   = out_ack;
    prev_out_event = out_event;
  end

  initial begin
    rst_n      = 1'b0;
    key_req    = 1'b0;
    key_in     = '0;
    out_ack    = 1'b0;
    out_count  = 0;
    out_pulses = 0;
    $readmemh("kbd_tests.txt", test_mem);
    n_events = int'(test_mem[0]);
    if (n_events < 1 || n_events > MAX_EVENTS) begin
      $display("Event count %0d read from kbd_tests.txt is out of range", n_events);
      fail_run();
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("key_ack after reset", key_ack, 1'b0);
    check_flag("out_req after reset", out_req, 1'b0);
    // Poller idles through several empty polls before the first key_req
    repeat (IDLE_CYCLES) @(posedge clk);
    fork
      drive_inputs();
      serve_outputs();
    join
    // A repeated event would raise out_req again within this window
    repeat (DRAIN_CYCLES) @(posedge clk);
    if (out_pulses == n_events) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("Saw %0d out_req pulses for %0d events", out_pulses, n_events);
      fail_run();
    end
  end

endmodule

// ==== kbd_io_top.sv ====
/*
 * Keyboard input subsystem top
 * Keyboard device (with its key port FIFO) polled by a bus-master poller
 */

`timescale 1ns/1ps

module kbd_io_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                key_req,
  input  kbd_pkg::key_event_t key_in,
  output logic                key_ack,
  output logic                out_req,
  output kbd_pkg::key_event_t out_event,
  input  logic                out_ack
);

  // Single-cycle bus between poller and device
  kbd_pkg::bus_req_t bus_req;
  kbd_pkg::bus_rsp_t bus_rsp;

  // Slave side with the input handshake and FIFO
  kbd_device u_device (
    .clk     (clk),
    .rst_n   (rst_n),
    .key_req (key_req),
    .key_in  (key_in),
    .key_ack (key_ack),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

  // Master side that drives the output handshake
  kbd_poller u_poller (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .out_req   (out_req),
    .out_event (out_event),
    .out_ack   (out_ack)
  );

endmodule

// ==== kbd_poller.sv ====
/*
 * Keyboard poller
 * Bus master that polls the keyboard device status, fetches each key,
 * clears status and forwards the event over a four-phase req/ack port
 */

`timescale 1ns/1ps
`include "kbd_defines.svh"

module kbd_poller (
  input  logic                clk,
  input  logic                rst_n,
  output kbd_pkg::bus_req_t   bus_req,
  input  kbd_pkg::bus_rsp_t   bus_rsp,
  output logic                out_req,
  output kbd_pkg::key_event_t out_event,
  input  logic                out_ack
);

  localparam logic [31:0] BASE     = `KBD_BASE;
  localparam logic [3:0]  STAT_OFF = `KBD_REG_STAT;
  localparam logic [3:0]  KEY_OFF  = `KBD_REG_KEY;
  localparam int          GAP      = `KBD_POLL_GAP;
  localparam int          GAP_W    = $clog2(GAP + 1);

  kbd_pkg::poll_state_t state;
  kbd_pkg::poll_state_t state_nxt;
  logic [GAP_W-1:0]     gap_cnt;
  logic                 gap_done;

  assign gap_done = (gap_cnt == GAP_W'(GAP - 1));

  // Next state
  always_comb begin
    state_nxt = state;
    case (state)
      kbd_pkg::GAP: begin
        if (gap_done) begin
          state_nxt = kbd_pkg::RD_STAT;
        end
      end
      kbd_pkg::RD_STAT: begin
        // Nothing pending goes back to idle spacing
        if (bus_rsp.ack && bus_rsp.rdata[0]) begin
          state_nxt = kbd_pkg::RD_KEY;
        end else begin
          state_nxt = kbd_pkg::GAP;
        end
      end
      kbd_pkg::RD_KEY:   state_nxt = kbd_pkg::CLR_STAT;
      kbd_pkg::CLR_STAT: state_nxt = kbd_pkg::OUT_REQ;
      kbd_pkg::OUT_REQ: begin
        // Hold req until the sink acknowledges
        if (out_ack) begin
          state_nxt = kbd_pkg::OUT_WAIT;
        end
      end
      kbd_pkg::OUT_WAIT: begin
        if (!out_ack) begin
          state_nxt = kbd_pkg::GAP;
        end
      end
      default: state_nxt = kbd_pkg::GAP;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= kbd_pkg::GAP;
    end else begin
      state <= state_nxt;
    end
  end

  // Gap counter runs only in GAP and parks at zero elsewhere
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gap_cnt <= '0;
    end else if (state == kbd_pkg::GAP && !gap_done) begin
      gap_cnt <= gap_cnt + 1'b1;
    end else begin
      gap_cnt <= '0;
    end
  end

  // Bus request decoded from state with one cycle per access
  always_comb begin
    bus_req = '0;
    case (state)
      kbd_pkg::RD_STAT: begin
        bus_req.cyc  = 1'b1;
        bus_req.addr = {BASE[31:4], STAT_OFF};
      end
      kbd_pkg::RD_KEY: begin
        bus_req.cyc  = 1'b1;
        bus_req.addr = {BASE[31:4], KEY_OFF};
      end
      kbd_pkg::CLR_STAT: begin
        // wdata bit 0 low clears pending
        bus_req.cyc  = 1'b1;
        bus_req.we   = 1'b1;
        bus_req.addr = {BASE[31:4], STAT_OFF};
      end
      default: bus_req = '0;
    endcase
  end

  // Key read data is captured and held through the whole output handshake
  always_ff @(posedge clk) begin
    if (state == kbd_pkg::RD_KEY) begin
      out_event <= kbd_pkg::key_event_t'(bus_rsp.rdata[8:0]);
    end
  end

  assign out_req = (state == kbd_pkg::OUT_REQ);

endmodule

// ==== kbd_device.sv ====
/*
 * Keyboard device
 * Memory-mapped bus slave with status and key registers, fed by the
 * key port FIFO held inside it
 */

`timescale 1ns/1ps
`include "kbd_defines.svh"

module kbd_device (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                key_req,
  input  kbd_pkg::key_event_t key_in,
  output logic                key_ack,
  input  kbd_pkg::bus_req_t   bus_req,
  output kbd_pkg::bus_rsp_t   bus_rsp
);

  localparam logic [31:0] BASE     = `KBD_BASE;
  localparam logic [3:0]  STAT_OFF = `KBD_REG_STAT;
  localparam logic [3:0]  KEY_OFF  = `KBD_REG_KEY;

  // Key port to device
  logic                fifo_valid;
  kbd_pkg::key_event_t fifo_head;
  logic                fifo_pop;

  logic                addr_hit;
  logic                key_sel;
  logic                stat_clr;
  logic                pending;
  kbd_pkg::key_event_t key_reg;
  logic                load;

  kbd_key_port u_key_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .key_req    (key_req),
    .key_in     (key_in),
    .key_ack    (key_ack),
    .fifo_pop   (fifo_pop),
    .fifo_valid (fifo_valid),
    .fifo_head  (fifo_head)
  );

  // Base decode on the upper address bits gives a same-cycle ack
  assign addr_hit    = bus_req.cyc & (bus_req.addr[31:4] == BASE[31:4]);
  assign bus_rsp.ack = addr_hit;

  // Address bit 2 tells the key register from status
  assign key_sel = (bus_req.addr[2] == KEY_OFF[2]);

  // Status reads pending in bit 0 and key reads the zero-extended event
  assign bus_rsp.rdata = key_sel ? {23'd0, key_reg} : {31'd0, pending};

  // Writing status with bit 0 low clears pending
  // Writes to the key register have no effect
  assign stat_clr = addr_hit & bus_req.we & (bus_req.addr[3:0] == STAT_OFF) &
                    ~bus_req.wdata[0];

  // Take the next event as soon as the register is free
  assign load     = ~pending & fifo_valid;
  assign fifo_pop = load;

  // Load and clear never overlap since clear needs pending set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (load) begin
      pending <= 1'b1;
    end else if (stat_clr) begin
      pending <= 1'b0;
    end
  end

  // Key register payload
  always_ff @(posedge clk) begin
    if (load) begin
      key_reg <= fifo_head;
    end
  end

endmodule

// ==== kbd_key_port.sv ====
/*
 * Keyboard key port
 * Receives key events over a four-phase req/ack handshake and queues
 * them in a small circular FIFO, oldest entry offered at fifo_head
 */

`timescale 1ns/1ps
`include "kbd_defines.svh"

module kbd_key_port (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                key_req,
  input  kbd_pkg::key_event_t key_in,
  output logic                key_ack,
  input  logic                fifo_pop,
  output logic                fifo_valid,
  output kbd_pkg::key_event_t fifo_head
);

  localparam int DEPTH = `KBD_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  // Event storage
  kbd_pkg::key_event_t mem [0:DEPTH-1];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             push;
  logic             pop;

  assign full       = (count == (PTR_W + 1)'(DEPTH));
  assign fifo_valid = (count != '0);
  assign fifo_head  = mem[rd_ptr];

  // A new request is taken only once ack is low again
  // A full FIFO holds off the ack to apply back-pressure
  assign push = key_req & ~key_ack & ~full;
  assign pop  = fifo_pop & fifo_valid;

  // Phase tracker for the receive handshake
  // key_ack high means this req pulse has already been stored
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_ack <= 1'b0;
    end else if (push) begin
      key_ack <= 1'b1;
    end else if (!key_req) begin
      // Source dropped req so the cycle closes
      key_ack <= 1'b0;
    end
  end

  // Write side of the buffer
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= key_in;
    end
  end

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy holds on a simultaneous push and pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== kbd_pkg.sv ====
/*
 * Keyboard subsystem types
 * Key event payload, single-cycle bus request and response,
 * and the poller FSM state encoding
 */

package kbd_pkg;

  // One key event as seen on both four-phase ports
  // Release flag sits above code so the pair maps straight onto key register bits 8..0
  typedef struct packed {
    logic       released;  // 1 = key released, 0 = key pressed
    logic [7:0] code;
  } key_event_t;

  // Bus master to slave
  typedef struct packed {
    logic        cyc;    // transaction active this cycle
    logic        we;     // write
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  // Slave response to the bus master in the request cycle
  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } bus_rsp_t;

  // Poller FSM states
  typedef enum logic [2:0] {
    GAP      = 3'd0,  // idle spacing between status polls
    RD_STAT  = 3'd1,  // read status register
    RD_KEY   = 3'd2,  // read key register
    CLR_STAT = 3'd3,  // write status to clear pending
    OUT_REQ  = 3'd4,  // out_req high, waiting for out_ack
    OUT_WAIT = 3'd5   // out_req low, waiting for out_ack to drop
  } poll_state_t;

endpackage

// ==== kbd_defines.svh ====
/*
 * Keyboard subsystem constants
 * Device base address, register offsets, FIFO depth and poll spacing
 */

`ifndef KBD_DEFINES_SVH
`define KBD_DEFINES_SVH

// Device decodes addr[31:4] against this base
`define KBD_BASE 32'hC000_0000

// Byte offsets inside the device window
`define KBD_REG_STAT 4'h0
`define KBD_REG_KEY  4'h4

// Key port FIFO entries, power of two, 2 or more
`define KBD_FIFO_DEPTH 4

// Idle cycles ahead of every status read, 1 or more
`define KBD_POLL_GAP 4

`endif
